/* vldu.f */
+incdir+source
+incdir+bench
source/vldu_cfg_pkg.sv
source/vldu_if_pkg.sv
source/vldu_insn_queue.sv
source/vldu_beat_unpacker.sv
source/vldu_result_queue.sv
source/vldu.sv
bench/vldu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the load unit testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vldu.f \
  --top-module vldu_tb \
  -o vldu_sim

# The simulator exits with an error on a failed check, the log decides
./obj_dir/vldu_sim 2>&1 | tee sim.log || true

if grep -q "Simulation failed" sim.log; then
  echo "Load unit test failed"
  exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
  echo "Load unit test did not finish"
  exit 1
fi

echo "Load unit test finished"

/* bench/vldu_tb_table.svh */
// Load table, memory contents and reference lane word model that the load unit testbench includes
`ifndef VLDU_TB_TABLE_SVH
`define VLDU_TB_TABLE_SVH

localparam int nr_insn  = 7;
// Memory bytes reserved per instruction to cover four register words
localparam int mem_span = 128;

// One row per load with the id equal to the row index
// Destination register of each load
localparam int tab_vd [nr_insn]  = '{1, 2, 3, 4, 5, 6, 7};
// Element count of each load
localparam int tab_vl [nr_insn]  = '{8, 37, 20, 13, 3, 50, 16};
// Element width as log2 of the byte count
localparam int tab_sew [nr_insn] = '{3, 0, 1, 2, 3, 1, 0};

// Memory bytes of each load in sequential order
logic [7:0] mem_bytes [nr_insn][mem_span];

// 32-bit xorshift generator with shift amounts 13 17 and 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic ld_req_t table_req(input int k);
  ld_req_t r;
  r.id   = vid_t'(k);
  r.vd   = vreg_t'(tab_vd[k]);
  r.vl   = vlen_t'(tab_vl[k]);
  r.vsew = vsew_e'(tab_sew[k]);
  return r;
endfunction

function automatic int elem_bytes(input int k);
  return 1 << tab_sew[k];
endfunction

// Register words of a load at 32 bytes each
function automatic int insn_words(input int k);
  return (tab_vl[k] * elem_bytes(k) + 31) / 32;
endfunction

// Aligned memory beats of a load at 8 bytes each
function automatic int insn_beats(input int k);
  return (tab_vl[k] * elem_bytes(k) + 7) / 8;
endfunction

// Lane word l of register word n of load k
function automatic lane_word_t expected_lane_word(input int k, input int n, input int l);
  lane_word_t lw;
  int w;
  int gb;
  int e;
  int off;
  w       = elem_bytes(k);
  lw      = '0;
  lw.id   = vid_t'(k);
  lw.addr = vaddr_t'(tab_vd[k] * 4 + n);
  for (int b = 0; b < 32; b++) begin
    gb = n * 32 + b;
    e  = gb / w;
    // Element e lives in lane e mod 4
    if (e < tab_vl[k] && e % 4 == l) begin
      off = ((e / 4) % (8 / w)) * w + gb % w;
      lw.data[8*off +: 8] = mem_bytes[k][gb];
      lw.be[off]          = 1'b1;
    end
  end
  return lw;
endfunction

`endif

/* bench/vldu_tb.sv */
// Vector load unit testbench that runs the load table against a randomly granting lane model
`timescale 1ns/1ns
`include "vldu_macros.svh"

module vldu_tb;

  import vldu_cfg_pkg::*;
  import vldu_if_pkg::*;

  `include "vldu_tb_table.svh"

  localparam int nr_lanes  = `VLDU_NR_LANES;
  localparam int max_words = 32;
  localparam int timeout   = 20000;

  logic                clk_i;
  logic                rst_ni;
  ld_req_t             ld_req_i;
  logic                ld_req_valid_i;
  logic                ld_req_ready_o;
  ld_resp_t            ld_resp_o;
  mem_beat_t           mem_beat_i;
  logic                mem_valid_i;
  logic                mem_ready_o;
  vrf_word_t           vrf_word_o;
  logic [nr_lanes-1:0] lane_req_o;
  logic [nr_lanes-1:0] lane_gnt_i;

  logic [31:0]         rng_state;
  // Lane model grants only while this is set
  logic                grant_en;
  logic [nr_lanes-1:0] gnt_next;
  int                  accepted_cnt;
  int                  done_cnt;
  int                  total_words;
  // Flat list of register words in commit order
  int                  word_insn [max_words];
  int                  word_num [max_words];
  // Words committed once load k is done
  int                  word_end [nr_insn];
  // Words granted so far on each lane
  int                  granted [nr_lanes];

  vldu uut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ld_req_i       (ld_req_i),
    .ld_req_valid_i (ld_req_valid_i),
    .ld_req_ready_o (ld_req_ready_o),
    .ld_resp_o      (ld_resp_o),
    .mem_beat_i     (mem_beat_i),
    .mem_valid_i    (mem_valid_i),
    .mem_ready_o    (mem_ready_o),
    .vrf_word_o     (vrf_word_o),
    .lane_req_o     (lane_req_o),
    .lane_gnt_i     (lane_gnt_i)
  );

  always #4 clk_i = ~clk_i;

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (act === exp) else begin
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_waits(input int waits, input string what);
    assert (waits < timeout) else begin
      $display("Timeout while waiting for %s", what);
      stop_run();
    end
  endtask

  function automatic elen_t byte_mask(input strb_t be);
    elen_t m;
    for (int i = 0; i < 8; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  task automatic fill_memory();
    for (int k = 0; k < nr_insn; k++) begin
      for (int b = 0; b < mem_span; b++) begin
        rng_state       = xorshift32(rng_state);
        mem_bytes[k][b] = rng_state[7:0] ^ rng_state[23:16];
      end
    end
  endtask

  task automatic build_word_list();
    total_words = 0;
    for (int k = 0; k < nr_insn; k++) begin
      for (int n = 0; n < insn_words(k); n++) begin
        word_insn[total_words] = k;
        word_num[total_words]  = n;
        total_words++;
      end
      word_end[k] = total_words;
    end
  endtask

  // Called on a rising edge, returns on the edge that accepts the request
  task automatic send_insn(input int k);
    int waits;
    ld_req_i       <= table_req(k);
    ld_req_valid_i <= 1'b1;
    waits = 0;
    do begin
      @(negedge clk_i);
      waits++;
      check_waits(waits, "ld_req_ready_o");
    end while (!ld_req_ready_o);
    @(posedge clk_i);
    accepted_cnt++;
  endtask

  task automatic wait_done(input int n);
    int waits;
    waits = 0;
    while (done_cnt < n) begin
      @(posedge clk_i);
      waits++;
      check_waits(waits, "a done pulse");
    end
  endtask

  // Lane model picks grants for the next edge and checks each granted word
  // A lane whose grant is still on the bus keeps its request until that edge
  always @(negedge clk_i) begin
    lane_word_t got;
    lane_word_t exp;
    int g;
    rng_state = xorshift32(rng_state);
    gnt_next  = '0;
    if (rst_ni && grant_en) begin
      for (int l = 0; l < nr_lanes; l++) begin
        if (lane_req_o[l] && !lane_gnt_i[l] && rng_state[l]) begin
          g = granted[l];
          assert (g < total_words) else begin
            $display("Lane %0d requests more words than the loads produce", l);
            stop_run();
          end
          exp      = expected_lane_word(word_insn[g], word_num[g], l);
          got      = vrf_word_o.lane[l];
          got.data = got.data & byte_mask(got.be);
          check_value($sformatf("vrf_word_o.lane[%0d]", l), exp, got);
          granted[l]  = g + 1;
          gnt_next[l] = 1'b1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    lane_gnt_i <= gnt_next;
  end

  // Done pulses come in acceptance order, one per load
  always @(negedge clk_i) begin
    logic [7:0] done_exp;
    if (rst_ni && ld_resp_o.vinsn_done != '0) begin
      done_exp = '0;
      if (done_cnt < 8) begin
        done_exp[done_cnt] = 1'b1;
      end
      check_value("ld_resp_o.vinsn_done", 128'(done_exp), 128'(ld_resp_o.vinsn_done));
      for (int l = 0; l < nr_lanes; l++) begin
        assert (granted[l] >= word_end[done_cnt]) else begin
          $display("Done pulse of load %0d came before its last word was granted", done_cnt);
          stop_run();
        end
      end
      done_cnt++;
    end
  end

  // Memory model streams the beats of each accepted load in order
  initial begin
    mem_beat_t beat;
    int waits;
    mem_beat_i  = '0;
    mem_valid_i = 1'b0;
    for (int k = 0; k < nr_insn; k++) begin
      waits = 0;
      do begin
        @(negedge clk_i);
        waits++;
        check_waits(waits, "the next load to be accepted");
      end while (accepted_cnt <= k);
      @(posedge clk_i);
      for (int bt = 0; bt < insn_beats(k); bt++) begin
        for (int i = 0; i < 8; i++) begin
          beat.data[8*i +: 8] = mem_bytes[k][bt*8 + i];
        end
        mem_beat_i  <= beat;
        mem_valid_i <= 1'b1;
        waits = 0;
        do begin
          @(negedge clk_i);
          waits++;
          check_waits(waits, "mem_ready_o");
        end while (!mem_ready_o);
        @(posedge clk_i);
      end
      mem_valid_i <= 1'b0;
    end
  end

  initial begin
    int waits;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    ld_req_i       = '0;
    ld_req_valid_i = 1'b0;
    lane_gnt_i     = '0;
    gnt_next       = '0;
    grant_en       = 1'b0;
    accepted_cnt   = 0;
    done_cnt       = 0;
    for (int l = 0; l < nr_lanes; l++) begin
      granted[l] = 0;
    end
    rng_state = 32'hee9a_d0da;
    fill_memory();
    build_word_list();

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Idle outputs after reset
    @(negedge clk_i);
    check_value("mem_ready_o", 128'(0), 128'(mem_ready_o));
    check_value("lane_req_o", 128'(0), 128'(lane_req_o));
    check_value("ld_resp_o", 128'(0), 128'(ld_resp_o));
    check_value("ld_req_ready_o", 128'(1), 128'(ld_req_ready_o));

    // EW64 and EW8 loads under random grants
    @(posedge clk_i);
    grant_en <= 1'b1;
    send_insn(0);
    send_insn(1);
    ld_req_valid_i <= 1'b0;
    wait_done(2);

    // Four loads fill the instruction queue while no grants are given
    grant_en <= 1'b0;
    for (int k = 2; k < 6; k++) begin
      send_insn(k);
    end
    ld_req_valid_i <= 1'b0;
    @(negedge clk_i);
    check_value("ld_req_ready_o", 128'(0), 128'(ld_req_ready_o));

    // Fifth load is held off until a done pulse frees a slot
    @(posedge clk_i);
    ld_req_i       <= table_req(6);
    ld_req_valid_i <= 1'b1;
    repeat (10) begin
      @(negedge clk_i);
      check_value("ld_req_ready_o", 128'(0), 128'(ld_req_ready_o));
    end
    // Ungranted words of the first queued load leave no room for beats
    check_value("mem_ready_o", 128'(0), 128'(mem_ready_o));
    grant_en <= 1'b1;
    waits = 0;
    do begin
      @(negedge clk_i);
      waits++;
      check_waits(waits, "ld_req_ready_o after grants resume");
    end while (!ld_req_ready_o);
    @(posedge clk_i);
    ld_req_valid_i <= 1'b0;
    accepted_cnt++;
    assert (done_cnt >= 3) else begin
      $display("Fifth load was accepted before any queued load was done");
      stop_run();
    end

    wait_done(nr_insn);
    for (int l = 0; l < nr_lanes; l++) begin
      check_value($sformatf("granted words of lane %0d", l), 128'(total_words),
                  128'(granted[l]));
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

/* source/vldu.sv */
// Vector load unit top level, joins the instruction queue, beat unpacker and result queue
`timescale 1ns/1ns
`include "vldu_macros.svh"

module vldu (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Sequencer
  input  vldu_if_pkg::ld_req_t      ld_req_i,
  input  logic                      ld_req_valid_i,
  output logic                      ld_req_ready_o,
  output vldu_if_pkg::ld_resp_t     ld_resp_o,
  // Memory read data
  input  vldu_if_pkg::mem_beat_t    mem_beat_i,
  input  logic                      mem_valid_i,
  output logic                      mem_ready_o,
  // Lanes
  output vldu_if_pkg::vrf_word_t    vrf_word_o,
  output logic [`VLDU_NR_LANES-1:0] lane_req_o,
  input  logic [`VLDU_NR_LANES-1:0] lane_gnt_i
);

  import vldu_cfg_pkg::*;
  import vldu_if_pkg::*;

  // Issuing instruction and its element count
  ld_req_t   issue_insn;
  logic      issue_valid;
  vlen_t     issue_cnt;
  logic      issue_done;

  // Finished words into the result queue
  vrf_word_t word;
  logic      word_push;
  logic      rq_full;

  // Head word granted by all lanes
  logic      word_pop;

  vldu_insn_queue i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ld_req_i       (ld_req_i),
    .ld_req_valid_i (ld_req_valid_i),
    .ld_req_ready_o (ld_req_ready_o),
    .ld_resp_o      (ld_resp_o),
    .issue_insn_o   (issue_insn),
    .issue_valid_o  (issue_valid),
    .issue_cnt_o    (issue_cnt),
    .issue_done_i   (issue_done),
    .word_pop_i     (word_pop)
  );

  vldu_beat_unpacker i_beat_unpacker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mem_beat_i    (mem_beat_i),
    .mem_valid_i   (mem_valid_i),
    .mem_ready_o   (mem_ready_o),
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .issue_cnt_i   (issue_cnt),
    .issue_done_o  (issue_done),
    .rq_full_i     (rq_full),
    .word_o        (word),
    .word_push_o   (word_push)
  );

  vldu_result_queue i_result_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .word_i      (word),
    .word_push_i (word_push),
    .rq_full_o   (rq_full),
    .vrf_word_o  (vrf_word_o),
    .lane_req_o  (lane_req_o),
    .lane_gnt_i  (lane_gnt_i),
    .word_pop_o  (word_pop)
  );

endmodule

/* source/vldu_result_queue.sv */
// Result queue, buffers finished register words and writes them to the lanes by request and grant
`timescale 1ns/1ns
`include "vldu_macros.svh"

module vldu_result_queue (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Words from the unpacker
  input  vldu_if_pkg::vrf_word_t       word_i,
  input  logic                         word_push_i,
  output logic                         rq_full_o,
  // Lane write port
  output vldu_if_pkg::vrf_word_t       vrf_word_o,
  output logic [`VLDU_NR_LANES-1:0]    lane_req_o,
  input  logic [`VLDU_NR_LANES-1:0]    lane_gnt_i,
  // Whole entry accepted by all lanes
  output logic                         word_pop_o
);

  import vldu_if_pkg::*;

  localparam int unsigned depth = `VLDU_RESULT_DEPTH;
  localparam int unsigned pnt_w = $clog2(depth);

  // Entry payload
  vrf_word_t [depth-1:0] entry_q;

  // Pending lane requests per entry
  logic [depth-1:0][`VLDU_NR_LANES-1:0] valid_q, valid_d;

  logic [pnt_w-1:0] rd_pnt_q, rd_pnt_d;
  logic [pnt_w-1:0] wr_pnt_q, wr_pnt_d;
  // Entries still owed to the lanes
  logic [pnt_w:0]   cnt_q, cnt_d;

  assign rq_full_o  = (cnt_q == depth);
  // Only the head entry is shown to the lanes
  assign vrf_word_o = entry_q[rd_pnt_q];
  assign lane_req_o = valid_q[rd_pnt_q];

  always_comb begin
    valid_d    = valid_q;
    rd_pnt_d   = rd_pnt_q;
    wr_pnt_d   = wr_pnt_q;
    cnt_d      = cnt_q;
    word_pop_o = 1'b0;

    // Each lane drops out on its own grant
    valid_d[rd_pnt_q] = valid_q[rd_pnt_q] & ~lane_gnt_i;

    // Last outstanding lane granted, retire the head entry
    if (cnt_q != '0 && valid_d[rd_pnt_q] == '0) begin
      word_pop_o = 1'b1;
      cnt_d      = cnt_q - 1'b1;
      if (rd_pnt_q == pnt_w'(depth - 1)) begin
        rd_pnt_d = '0;
      end else begin
        rd_pnt_d = rd_pnt_q + 1'b1;
      end
    end

    // New word requests every lane, even lanes with no enables set
    if (word_push_i) begin
      valid_d[wr_pnt_q] = '1;
      cnt_d             = cnt_d + 1'b1;
      if (wr_pnt_q == pnt_w'(depth - 1)) begin
        wr_pnt_d = '0;
      end else begin
        wr_pnt_d = wr_pnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_push_i) begin
      entry_q[wr_pnt_q] <= word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rd_pnt_q <= '0;
      wr_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      rd_pnt_q <= rd_pnt_d;
      wr_pnt_q <= wr_pnt_d;
      cnt_q    <= cnt_d;
    end
  end

endmodule

/* source/vldu_beat_unpacker.sv */
// Beat unpacker, spreads memory beats over the lanes and pushes each finished register word
`timescale 1ns/1ns
`include "vldu_macros.svh"

module vldu_beat_unpacker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Memory read beats
  input  vldu_if_pkg::mem_beat_t mem_beat_i,
  input  logic                   mem_valid_i,
  output logic                   mem_ready_o,
  // Issuing instruction
  input  vldu_if_pkg::ld_req_t   issue_insn_i,
  input  logic                   issue_valid_i,
  input  vldu_cfg_pkg::vlen_t    issue_cnt_i,
  output logic                   issue_done_o,
  // Result queue
  input  logic                   rq_full_i,
  output vldu_if_pkg::vrf_word_t word_o,
  output logic                   word_push_o
);

  import vldu_cfg_pkg::*;
  import vldu_if_pkg::*;

  localparam int unsigned beat_bytes    = `VLDU_MEM_WIDTH / 8;
  localparam int unsigned word_bytes    = `VLDU_NR_LANES * `VLDU_ELEN / 8;
  localparam int unsigned pnt_w         = $clog2(word_bytes);
  localparam int unsigned lane_w        = $clog2(`VLDU_NR_LANES);
  localparam int unsigned off_w         = $clog2(`VLDU_ELEN / 8);
  localparam int unsigned words_per_reg = `VLDU_VLEN / (`VLDU_NR_LANES * `VLDU_ELEN);
  localparam int unsigned byte_cnt_w    = $bits(vaddr_t) + pnt_w;

  // Sequential byte pointer inside the word being built
  logic [pnt_w-1:0] vrf_pnt_q, vrf_pnt_d;
  // Index of that word inside the instruction
  vaddr_t           word_num_q, word_num_d;
  // Bytes gathered so far for the current word
  vrf_word_t        word_q, word_d;

  logic                  beat_fire;
  logic                  last_beat;
  logic                  word_full;
  logic [byte_cnt_w-1:0] beat_base;
  logic [byte_cnt_w-1:0] issue_bytes;
  logic [pnt_w-1:0]      sub_mask;
  logic [pnt_w-1:0]      seq_byte;
  logic [pnt_w-1:0]      elem_idx;
  logic [lane_w-1:0]     lane_idx;
  logic [off_w-1:0]      lane_off;

  // Room in the result queue is enough, a beat never waits for a partial word
  assign mem_ready_o = issue_valid_i && !rq_full_i;
  assign beat_fire   = mem_valid_i && mem_ready_o;

  // Instruction byte offset of the first byte in this beat
  assign beat_base   = {word_num_q, vrf_pnt_q};
  assign issue_bytes = byte_cnt_w'(issue_cnt_i) << issue_insn_i.vsew;
  assign last_beat   = (beat_base + byte_cnt_w'(beat_bytes)) >= issue_bytes;
  assign word_full   = (vrf_pnt_q == pnt_w'(word_bytes - beat_bytes));

  assign word_push_o  = beat_fire && (word_full || last_beat);
  assign issue_done_o = beat_fire && last_beat;
  assign word_o       = word_d;

  always_comb begin
    word_d     = word_q;
    vrf_pnt_d  = vrf_pnt_q;
    word_num_d = word_num_q;
    seq_byte   = '0;
    elem_idx   = '0;
    lane_idx   = '0;
    lane_off   = '0;
    // Low bits selecting a byte inside one element
    sub_mask   = (pnt_w'(1) << issue_insn_i.vsew) - 1'b1;

    if (beat_fire) begin
      for (int i = 0; i < beat_bytes; i++) begin
        seq_byte = vrf_pnt_q + pnt_w'(i);
        // Element number inside the word picks the lane
        elem_idx = seq_byte >> issue_insn_i.vsew;
        lane_idx = elem_idx[lane_w-1:0];
        // Elements of one lane stack up from the bottom of the lane word
        lane_off = off_w'(((elem_idx >> lane_w) << issue_insn_i.vsew) | (seq_byte & sub_mask));
        // Bytes past vl keep a cleared enable
        if ({word_num_q, seq_byte} < issue_bytes) begin
          word_d.lane[lane_idx].data[8*lane_off +: 8] = mem_beat_i.data[8*i +: 8];
          word_d.lane[lane_idx].be[lane_off]          = 1'b1;
        end
      end

      // Pointer wraps to zero by itself when the word fills up
      vrf_pnt_d = vrf_pnt_q + pnt_w'(beat_bytes);
      if (word_push_o) begin
        word_num_d = word_num_q + 1'b1;
      end
      // Next instruction starts on a fresh word
      if (issue_done_o) begin
        vrf_pnt_d  = '0;
        word_num_d = '0;
      end
    end

    // Same id for every lane, address vd times words per lane register plus word index
    for (int l = 0; l < `VLDU_NR_LANES; l++) begin
      word_d.lane[l].id   = issue_insn_i.id;
      word_d.lane[l].addr = vaddr_t'(issue_insn_i.vd * words_per_reg + word_num_q);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vrf_pnt_q  <= '0;
      word_num_q <= '0;
      word_q     <= '0;
    end else begin
      vrf_pnt_q  <= vrf_pnt_d;
      word_num_q <= word_num_d;
      // A pushed word leaves, the next one starts with no enables
      word_q     <= word_push_o ? '0 : word_d;
    end
  end

endmodule

/* source/vldu_insn_queue.sv */
// Load instruction queue, tracks each request from accept through issue and commit
`timescale 1ns/1ns
`include "vldu_macros.svh"

module vldu_insn_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer
  input  vldu_if_pkg::ld_req_t  ld_req_i,
  input  logic                  ld_req_valid_i,
  output logic                  ld_req_ready_o,
  output vldu_if_pkg::ld_resp_t ld_resp_o,
  // Issuing instruction toward the unpacker
  output vldu_if_pkg::ld_req_t  issue_insn_o,
  output logic                  issue_valid_o,
  output vldu_cfg_pkg::vlen_t   issue_cnt_o,
  input  logic                  issue_done_i,
  // One register word fully granted by the lanes
  input  logic                  word_pop_i
);

  import vldu_cfg_pkg::*;
  import vldu_if_pkg::*;

  localparam int unsigned depth = `VLDU_INSN_DEPTH;
  localparam int unsigned pnt_w = $clog2(depth);

  // Instruction storage
  ld_req_t [depth-1:0] insn_q;

  // Ring pointers for the three phases
  logic [pnt_w-1:0] accept_pnt_q, accept_pnt_d;
  logic [pnt_w-1:0] issue_pnt_q, issue_pnt_d;
  logic [pnt_w-1:0] commit_pnt_q, commit_pnt_d;

  // Instructions still waiting to finish issue and commit
  logic [pnt_w:0] issue_cnt_q, issue_cnt_d;
  logic [pnt_w:0] commit_cnt_q, commit_cnt_d;

  // Elements left in the head instruction of each phase
  vlen_t issue_elems_q, issue_elems_d;
  vlen_t commit_elems_q, commit_elems_d;

  ld_req_t  commit_insn;
  vlen_t    word_elems;
  ld_resp_t resp_d;

  // A request is taken whenever a slot is free, even while others commit
  assign ld_req_ready_o = (commit_cnt_q != depth);

  assign issue_insn_o  = insn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_cnt_o   = issue_elems_q;

  assign commit_insn = insn_q[commit_pnt_q];
  // Elements carried by one register word, 32 bytes over the element width
  assign word_elems  = vlen_t'((`VLDU_NR_LANES * 8) >> commit_insn.vsew);

  always_comb begin
    accept_pnt_d   = accept_pnt_q;
    issue_pnt_d    = issue_pnt_q;
    commit_pnt_d   = commit_pnt_q;
    issue_cnt_d    = issue_cnt_q;
    commit_cnt_d   = commit_cnt_q;
    issue_elems_d  = issue_elems_q;
    commit_elems_d = commit_elems_q;
    resp_d         = '0;

    // Unpacker packed the last element, move on to the next instruction
    if (issue_done_i && issue_valid_o) begin
      issue_cnt_d   = issue_cnt_q - 1'b1;
      issue_pnt_d   = issue_pnt_q + 1'b1;
      issue_elems_d = '0;
      if (issue_cnt_d != '0) begin
        issue_elems_d = insn_q[issue_pnt_d].vl;
      end
    end

    // Each granted word retires one word's worth of elements
    if (word_pop_i && commit_cnt_q != '0) begin
      if (commit_elems_q > word_elems) begin
        commit_elems_d = commit_elems_q - word_elems;
      end else begin
        commit_elems_d = '0;
      end
      // Last word of the instruction, report it and load the next vl
      if (commit_elems_d == '0) begin
        resp_d.vinsn_done[commit_insn.id] = 1'b1;
        commit_cnt_d = commit_cnt_q - 1'b1;
        commit_pnt_d = commit_pnt_q + 1'b1;
        if (commit_cnt_d != '0) begin
          commit_elems_d = insn_q[commit_pnt_d].vl;
        end
      end
    end

    // New request, counters start from its vl when a phase runs empty
    if (ld_req_valid_i && ld_req_ready_o) begin
      if (issue_cnt_d == '0) begin
        issue_elems_d = ld_req_i.vl;
      end
      if (commit_cnt_d == '0) begin
        commit_elems_d = ld_req_i.vl;
      end
      accept_pnt_d = accept_pnt_q + 1'b1;
      issue_cnt_d  = issue_cnt_d + 1'b1;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_req_valid_i && ld_req_ready_o) begin
      insn_q[accept_pnt_q] <= ld_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q   <= '0;
      issue_pnt_q    <= '0;
      commit_pnt_q   <= '0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      issue_elems_q  <= '0;
      commit_elems_q <= '0;
      ld_resp_o      <= '0;
    end else begin
      accept_pnt_q   <= accept_pnt_d;
      issue_pnt_q    <= issue_pnt_d;
      commit_pnt_q   <= commit_pnt_d;
      issue_cnt_q    <= issue_cnt_d;
      commit_cnt_q   <= commit_cnt_d;
      issue_elems_q  <= issue_elems_d;
      commit_elems_q <= commit_elems_d;
      ld_resp_o      <= resp_d;
    end
  end

endmodule

/* source/vldu_if_pkg.sv */
// Packed structs exchanged between the load unit blocks and with the sequencer, memory and lanes
`include "vldu_macros.svh"

package vldu_if_pkg;

  import vldu_cfg_pkg::*;

  // Load request from the sequencer
  typedef struct packed {
    // Id returned in the done vector
    vid_t  id;
    // Destination register
    vreg_t vd;
    // Number of elements to load
    vlen_t vl;
    // Width of one element
    vsew_e vsew;
  } ld_req_t;

  // Completion report toward the sequencer
  typedef struct packed {
    // One bit per id, pulsed for a single cycle
    logic [`VLDU_NR_VINSN-1:0] vinsn_done;
  } ld_resp_t;

  // One aligned memory read beat
  typedef struct packed {
    logic [`VLDU_MEM_WIDTH-1:0] data;
  } mem_beat_t;

  // Write request for one lane
  typedef struct packed {
    vid_t   id;
    // Lane-local register file address
    vaddr_t addr;
    elen_t  data;
    // Set only for bytes of elements below vl
    strb_t  be;
  } lane_word_t;

  // Full register word, one lane word per lane
  // Element k of the word sits in lane k mod the lane count
  typedef struct packed {
    lane_word_t [`VLDU_NR_LANES-1:0] lane;
  } vrf_word_t;

endpackage

/* source/vldu_cfg_pkg.sv */
// Basic vector widths and the element-width encoding, imported by every load unit block
`include "vldu_macros.svh"

package vldu_cfg_pkg;

  // One lane data word
  typedef logic [`VLDU_ELEN-1:0] elen_t;

  // Byte enables of one lane word
  typedef logic [`VLDU_ELEN/8-1:0] strb_t;

  // Instruction id, one value per in-flight slot of the sequencer
  typedef logic [$clog2(`VLDU_NR_VINSN)-1:0] vid_t;

  // Architectural vector register number
  typedef logic [4:0] vreg_t;

  // Word address inside one lane of the register file
  typedef logic [6:0] vaddr_t;

  // Element count of an instruction
  typedef logic [7:0] vlen_t;

  // Element width
  // The encoding is log2 of the width in bytes, so it doubles as a shift amount
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

endpackage

/* source/vldu_macros.svh */
// Sizing macros of the vector load unit, included by the packages and the modules that need them
`ifndef VLDU_MACROS_SVH
`define VLDU_MACROS_SVH

// Number of lanes in the vector register file
`define VLDU_NR_LANES 4

// Bits per lane word
`define VLDU_ELEN 64

// Bits per memory read beat
`define VLDU_MEM_WIDTH 64

// Bits per vector register
`define VLDU_VLEN 1024

// Instructions held in flight by the unit
`define VLDU_INSN_DEPTH 4

// Register words buffered toward the lanes
`define VLDU_RESULT_DEPTH 2

// Distinct instruction ids handed out by the sequencer
`define VLDU_NR_VINSN 8

`endif
